// File: Makefile
# Verilator build and run of the LFSR testbench

VERILATOR ?= verilator
TOP       ?= lfsr_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= All checks passed

.PHONY: sim clean

# fails unless the pass line appears in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: design/fibonacci_tap_table.sv
////////////////////////////////////////////////////////////
// maximal-length tap masks, purely combinational
// lengths without an entry give mask 0 and mask_hit low
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fibonacci_tap_table (
    input  lfsr_pkg::length_t length,
    input  logic              four_taps,
    output lfsr_pkg::mask_t   mask,
    output logic              mask_hit
);
    import lfsr_pkg::*;

    mask_t mask_2;
    mask_t mask_4;

    ////////////////////////////////////////////////////////////
    // 2-tap table

    always_comb begin
        case (length)
            5'd2:    mask_2 = 32'h0000_0003;   // taps 0,1
            5'd3:    mask_2 = 32'h0000_0006;
            5'd4:    mask_2 = 32'h0000_000c;
            5'd5:    mask_2 = 32'h0000_0014;
            5'd6:    mask_2 = 32'h0000_0030;
            5'd7:    mask_2 = 32'h0000_0060;
            5'd9:    mask_2 = 32'h0000_0110;
            5'd10:   mask_2 = 32'h0000_0240;
            5'd11:   mask_2 = 32'h0000_0500;
            5'd15:   mask_2 = 32'h0000_6000;
            5'd17:   mask_2 = 32'h0001_2000;
            5'd18:   mask_2 = 32'h0002_0400;
            5'd20:   mask_2 = 32'h0009_0000;
            5'd21:   mask_2 = 32'h0014_0000;
            5'd22:   mask_2 = 32'h0030_0000;
            5'd23:   mask_2 = 32'h0042_0000;
            5'd25:   mask_2 = 32'h0120_0000;
            5'd28:   mask_2 = 32'h0900_0000;
            5'd29:   mask_2 = 32'h1400_0000;
            5'd31:   mask_2 = 32'h4800_0000;   // taps 27,30
            default: mask_2 = '0;              // no 2-tap polynomial
        endcase
    end

    ////////////////////////////////////////////////////////////
    // 4-tap table

    always_comb begin
        case (length)
            5'd5:    mask_4 = 32'h0000_001e;   // taps 1,2,3,4
            5'd6:    mask_4 = 32'h0000_0036;
            5'd7:    mask_4 = 32'h0000_0078;
            5'd8:    mask_4 = 32'h0000_00b8;
            5'd9:    mask_4 = 32'h0000_01b0;
            5'd10:   mask_4 = 32'h0000_0360;
            5'd11:   mask_4 = 32'h0000_0740;
            5'd12:   mask_4 = 32'h0000_0ca0;
            5'd13:   mask_4 = 32'h0000_1b00;
            5'd14:   mask_4 = 32'h0000_3500;
            5'd15:   mask_4 = 32'h0000_7400;
            5'd16:   mask_4 = 32'h0000_b400;
            5'd17:   mask_4 = 32'h0001_e000;
            5'd18:   mask_4 = 32'h0003_9000;
            5'd19:   mask_4 = 32'h0007_2000;
            5'd20:   mask_4 = 32'h000c_a000;
            5'd21:   mask_4 = 32'h001c_8000;
            5'd22:   mask_4 = 32'h0027_0000;
            5'd23:   mask_4 = 32'h006a_0000;
            5'd24:   mask_4 = 32'h00d8_0000;
            5'd25:   mask_4 = 32'h01e0_0000;
            5'd26:   mask_4 = 32'h0388_0000;
            5'd27:   mask_4 = 32'h0720_0000;
            5'd28:   mask_4 = 32'h0ca0_0000;
            5'd29:   mask_4 = 32'h1d00_0000;
            5'd30:   mask_4 = 32'h3280_0000;
            5'd31:   mask_4 = 32'h7800_0000;   // taps 27,28,29,30
            default: mask_4 = '0;              // lengths 0 to 4
        endcase
    end

    ////////////////////////////////////////////////////////////
    // table select

    // every real entry has taps, so an empty mask means no entry
    always_comb begin
        if (four_taps) begin
            mask     = mask_4;
            mask_hit = |mask_4;
        end else begin
            mask     = mask_2;
            mask_hit = |mask_2;
        end
    end

endmodule

`default_nettype wire

// File: design/lfsr_config.svh
////////////////////////////////////////////////////////////
// widths, seed and synchronizer depth for RTL and testbench
// state is always 32 bits, length only picks the tap mask
////////////////////////////////////////////////////////////

`ifndef LFSR_CONFIG_SVH
`define LFSR_CONFIG_SVH

// shift state and length selector
`define LFSR_STATE_WIDTH  32
`define LFSR_LENGTH_WIDTH 5

// visible slice, taken from the low state bits
`define LFSR_OUT_WIDTH    15

`define LFSR_SEED         32'h0000_0001   // state after reset

// button synchronizer, must be 2 or more
`define STEP_SYNC_STAGES  2

`endif

// File: design/lfsr_core.sv
////////////////////////////////////////////////////////////
// whole 32-bit state shifts whatever the selected length
// a missing table entry locks the state at 0 until reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lfsr_config.svh"

module lfsr_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  lfsr_pkg::mask_t      mask,
    input  logic                 mask_hit,
    output lfsr_pkg::out_value_t value,
    output logic                 valid
);
    import lfsr_pkg::*;

    state_t state;
    logic   state_valid;
    logic   feedback;

    assign feedback = ^(state & mask);   // parity of the tapped bits

    ////////////////////////////////////////////////////////////
    // shift register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= `LFSR_SEED;
            state_valid <= 1'b1;
        end else if (advance) begin
            if (mask_hit) begin
                state       <= {state[`LFSR_STATE_WIDTH-2:0], feedback};
                state_valid <= 1'b1;
            end else begin
                state       <= '0;       // invalid length
                state_valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output register, one cycle behind the state

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value <= '0;
            valid <= 1'b0;
        end else begin
            value <= state[`LFSR_OUT_WIDTH-1:0];
            valid <= state_valid;
        end
    end

endmodule

`default_nettype wire

// File: design/lfsr_pkg.sv
////////////////////////////////////////////////////////////
// datapath types of the lfsr, sized from the config header
////////////////////////////////////////////////////////////

`default_nettype none

`include "lfsr_config.svh"

package lfsr_pkg;

    // full shift register, never truncated to the length
    typedef logic [`LFSR_STATE_WIDTH-1:0]  state_t;

    typedef logic [`LFSR_STATE_WIDTH-1:0]  mask_t;      // bit i set: state[i] feeds parity
    typedef logic [`LFSR_LENGTH_WIDTH-1:0] length_t;    // 2..31 usable
    typedef logic [`LFSR_OUT_WIDTH-1:0]    out_value_t;

endpackage

`default_nettype wire

// File: design/lfsr_top.sv
////////////////////////////////////////////////////////////
// length and four_taps are static and used unsynchronized
// hold and step may come straight from buttons
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module lfsr_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lfsr_pkg::length_t    length,
    input  logic                 four_taps,
    input  logic                 hold,
    input  logic                 step,
    output lfsr_pkg::out_value_t value,
    output logic                 valid
);
    import lfsr_pkg::*;

    logic  advance;    // one strobe per shift
    mask_t mask;
    logic  mask_hit;

    step_control i_step_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold    (hold),
        .step    (step),
        .advance (advance)
    );

    fibonacci_tap_table i_fibonacci_tap_table (
        .length    (length),
        .four_taps (four_taps),
        .mask      (mask),
        .mask_hit  (mask_hit)
    );

    lfsr_core i_lfsr_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .mask     (mask),
        .mask_hit (mask_hit),
        .value    (value),
        .valid    (valid)
    );

endmodule

`default_nettype wire

// File: design/step_control.sv
////////////////////////////////////////////////////////////
// hold and step are raw buttons, synchronized here
// advance is registered, so it is low in the first cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lfsr_config.svh"

module step_control #(
    parameter int SYNC_STAGES = `STEP_SYNC_STAGES
) (
    input  logic clk,
    input  logic rst_n,
    input  logic hold,
    input  logic step,
    output logic advance
);
    import step_pkg::*;

    logic [SYNC_STAGES-1:0] hold_sync;
    logic [SYNC_STAGES-1:0] step_sync;
    logic                   hold_s;
    logic                   step_s;
    step_state_t            state;
    step_state_t            state_nxt;
    logic                   advance_nxt;

    // button synchronizers, msb is the settled value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_sync <= '0;
            step_sync <= '0;
        end else begin
            hold_sync <= {hold_sync[SYNC_STAGES-2:0], hold};
            step_sync <= {step_sync[SYNC_STAGES-2:0], step};
        end
    end

    assign hold_s = hold_sync[SYNC_STAGES-1];
    assign step_s = step_sync[SYNC_STAGES-1];

    ////////////////////////////////////////////////////////////
    // control FSM

    always_comb begin
        state_nxt   = state;
        advance_nxt = 1'b0;
        case (state)
            RUN: begin
                if (hold_s) begin
                    state_nxt = HELD;
                end else begin
                    advance_nxt = 1'b1;      // free run
                end
            end
            HELD: begin
                if (!hold_s) begin
                    state_nxt = RUN;
                end else if (step_s) begin
                    state_nxt   = STEPPED;
                    advance_nxt = 1'b1;      // one step per press
                end
            end
            STEPPED: begin
                // hold release wins over step release
                if (!hold_s) begin
                    state_nxt = RUN;
                end else if (!step_s) begin
                    state_nxt = HELD;
                end
            end
            default: state_nxt = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= RUN;
            advance <= 1'b0;
        end else begin
            state   <= state_nxt;
            advance <= advance_nxt;
        end
    end

endmodule

`default_nettype wire

// File: design/step_pkg.sv
////////////////////////////////////////////////////////////
// states of the hold and step control
////////////////////////////////////////////////////////////

`default_nettype none

package step_pkg;

    typedef enum logic [1:0] {
        RUN     = 2'd0,   // advance every cycle
        HELD    = 2'd1,   // waiting for a press
        STEPPED = 2'd2    // press taken, waiting for release
    } step_state_t;

endpackage

`default_nettype wire

// File: list.f
+incdir+design
+incdir+testbench
design/lfsr_pkg.sv
design/step_pkg.sv
design/fibonacci_tap_table.sv
design/step_control.sv
design/lfsr_core.sv
design/lfsr_top.sv
testbench/lfsr_tb.sv

// File: testbench/lfsr_model.svh
////////////////////////////////////////////////////////////
// cycle model of lfsr_top for inclusion in the testbench module
// lfsr_pkg and step_pkg must be imported before the include
////////////////////////////////////////////////////////////

`ifndef LFSR_MODEL_SVH
`define LFSR_MODEL_SVH

`include "lfsr_config.svh"

localparam logic [4:0] no_tap = 5'd31;   // never a low tap

// low tap of each 2-tap entry
localparam logic [4:0] taps2_low [32] = '{
    no_tap, no_tap, 5'd0, 5'd1, 5'd2, 5'd2, 5'd4, 5'd5,
    no_tap, 5'd4, 5'd6, 5'd8, no_tap, no_tap, no_tap, 5'd13,
    no_tap, 5'd13, 5'd10, no_tap, 5'd16, 5'd18, 5'd20, 5'd17,
    no_tap, 5'd21, no_tap, no_tap, 5'd24, 5'd26, no_tap, 5'd27
};

// three low taps of each 4-tap entry
localparam logic [14:0] taps4_low [32] = '{
    15'd0, 15'd0, 15'd0, 15'd0,   // lengths 0 to 4 have none
    15'd0, {5'd1, 5'd2, 5'd3}, {5'd1, 5'd2, 5'd4}, {5'd3, 5'd4, 5'd5},
    {5'd3, 5'd4, 5'd5}, {5'd4, 5'd5, 5'd7}, {5'd5, 5'd6, 5'd8}, {5'd6, 5'd8, 5'd9},
    {5'd5, 5'd7, 5'd10}, {5'd8, 5'd9, 5'd11}, {5'd8, 5'd10, 5'd12}, {5'd10, 5'd12, 5'd13},
    {5'd10, 5'd12, 5'd13}, {5'd13, 5'd14, 5'd15}, {5'd12, 5'd15, 5'd16}, {5'd13, 5'd16, 5'd17},
    {5'd13, 5'd15, 5'd18}, {5'd15, 5'd18, 5'd19}, {5'd16, 5'd17, 5'd18}, {5'd17, 5'd19, 5'd21},
    {5'd19, 5'd20, 5'd22}, {5'd21, 5'd22, 5'd23}, {5'd19, 5'd23, 5'd24}, {5'd21, 5'd24, 5'd25},
    {5'd21, 5'd23, 5'd26}, {5'd24, 5'd26, 5'd27}, {5'd23, 5'd25, 5'd28}, {5'd27, 5'd28, 5'd29}
};

logic [`STEP_SYNC_STAGES-1:0] ref_hold_sync;
logic [`STEP_SYNC_STAGES-1:0] ref_step_sync;
step_state_t                  ref_ctrl;
logic                         ref_advance;
state_t                       ref_state;
logic                         ref_state_valid;
out_value_t                   ref_value;
logic                         ref_valid;

function automatic logic tap_hit(input length_t len, input logic four);
    if (four) begin
        return len >= 5'd5;
    end
    return taps2_low[len] != no_tap;
endfunction

function automatic mask_t tap_mask(input length_t len, input logic four);
    mask_t       m;
    logic [14:0] low3;
    m = '0;
    if (tap_hit(len, four)) begin
        m[len - 5'd1] = 1'b1;          // top tap is always length-1
        if (four) begin
            low3           = taps4_low[len];
            m[low3[14:10]] = 1'b1;
            m[low3[9:5]]   = 1'b1;
            m[low3[4:0]]   = 1'b1;
        end else begin
            m[taps2_low[len]] = 1'b1;
        end
    end
    return m;
endfunction

// one rising edge with the inputs sampled there
task automatic reference_step(input logic rst, input length_t len, input logic four,
                              input logic hold_in, input logic step_in);
    logic  hold_s;
    logic  step_s;
    mask_t m;
    hold_s = ref_hold_sync[`STEP_SYNC_STAGES-1];
    step_s = ref_step_sync[`STEP_SYNC_STAGES-1];
    m      = tap_mask(len, four);
    if (!rst) begin
        ref_hold_sync   = '0;
        ref_step_sync   = '0;
        ref_ctrl        = RUN;
        ref_advance     = 1'b0;
        ref_state       = `LFSR_SEED;
        ref_state_valid = 1'b1;
        ref_value       = '0;
        ref_valid       = 1'b0;
    end else begin
        ref_value = ref_state[`LFSR_OUT_WIDTH-1:0];   // output lags state
        ref_valid = ref_state_valid;
        if (ref_advance && tap_hit(len, four)) begin
            ref_state       = {ref_state[`LFSR_STATE_WIDTH-2:0], ^(ref_state & m)};
            ref_state_valid = 1'b1;
        end else if (ref_advance) begin
            ref_state       = '0;
            ref_state_valid = 1'b0;
        end
        ref_advance = 1'b0;
        case (ref_ctrl)
            RUN: begin
                if (hold_s) begin
                    ref_ctrl = HELD;
                end else begin
                    ref_advance = 1'b1;
                end
            end
            HELD: begin
                if (!hold_s) begin
                    ref_ctrl = RUN;
                end else if (step_s) begin
                    ref_ctrl    = STEPPED;
                    ref_advance = 1'b1;
                end
            end
            STEPPED: begin
                if (!hold_s) begin
                    ref_ctrl = RUN;
                end else if (!step_s) begin
                    ref_ctrl = HELD;
                end
            end
            default: ref_ctrl = RUN;
        endcase
        ref_hold_sync = {ref_hold_sync[`STEP_SYNC_STAGES-2:0], hold_in};
        ref_step_sync = {ref_step_sync[`STEP_SYNC_STAGES-2:0], step_in};
    end
endtask

`endif

// File: testbench/lfsr_tb.sv
////////////////////////////////////////////////////////////
// random lengths and button presses, checked each cycle
// against the model in lfsr_model.svh
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lfsr_config.svh"

module lfsr_tb;
    import lfsr_pkg::*;
    import step_pkg::*;

    localparam int reset_cycles   = 5;
    localparam int run_cycles     = 300;
    localparam int seg_cycles     = 64;
    localparam int segments       = 6;
    localparam int presses        = 12;
    localparam int invalid_cycles = 40;
    localparam int rerun_cycles   = 40;
    // press and gap are at most 6 cycles each, plus 4 to settle hold
    localparam int timeout_cycles = 2 * reset_cycles + run_cycles + segments * seg_cycles
                                  + 4 + presses * 12 + invalid_cycles + rerun_cycles + 200;

    logic       clk;
    logic       rst_n;
    length_t    length;
    logic       four_taps;
    logic       hold;
    logic       step;
    out_value_t value;
    logic       valid;

    logic [31:0] rng = 32'hdac1b39f;
    int          cycle_count = 0;
    int          checks;
    int          errors;
    int          test_errors;

    `include "lfsr_model.svh"

    lfsr_top i_lfsr_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .length    (length),
        .four_taps (four_taps),
        .hold      (hold),
        .step      (step),
        .value     (value),
        .valid     (valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("timeout: the tests did not end within %0d cycles", timeout_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb  = rng[31] ^ rng[21] ^ rng[1] ^ rng[0];
            rng = {rng[30:0], fb};
            r   = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic length_t pick_length(input logic four);
        length_t len;
        len = length_t'(random_bits(5));
        while (!tap_hit(len, four)) begin
            len = length_t'(random_bits(5));
        end
        return len;
    endfunction

    task automatic compare_value(input out_value_t got, input out_value_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %0d ns: value is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %0d ns: valid is %b, expected %b", $time, got, exp);
        end
    endtask

    // one edge, compare, then leave 1 ns after the edge for new inputs
    task automatic tick();
        @(posedge clk);
        reference_step(rst_n, length, four_taps, hold, step);
        #1;
        compare_value(value, ref_value);
        check_valid(valid, ref_valid);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (reset_cycles) tick();
        rst_n = 1'b1;
    endtask

    task automatic report_test(input string name);
        $display("test %s done, %0d mismatches", name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        int n;
        int p;
        int s;
        clk         = 1'b0;
        rst_n       = 1'b0;
        length      = 5'd2;
        four_taps   = 1'b0;
        hold        = 1'b0;
        step        = 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;

        length = pick_length(1'b0);
        apply_reset();
        repeat (run_cycles) tick();
        report_test("free run 2 taps");

        four_taps = 1'b1;
        for (s = 0; s < segments; s++) begin
            length = pick_length(1'b1);
            repeat (seg_cycles) tick();
        end
        report_test("free run 4 taps");

        four_taps = 1'b0;
        length    = pick_length(1'b0);
        hold      = 1'b1;
        repeat (4) tick();                 // hold through synchronizer
        for (p = 0; p < presses; p++) begin
            step = 1'b1;
            n    = 1 + int'(random_bits(8) % 6);
            repeat (n) tick();
            step = 1'b0;
            n    = 1 + int'(random_bits(8) % 6);
            repeat (n) tick();
        end
        hold = 1'b0;
        report_test("hold and step");

        length = 5'd8;                     // no 2-tap entry
        repeat (invalid_cycles / 2) tick();
        compare_value(value, '0);
        check_valid(valid, 1'b0);
        length = pick_length(1'b0);
        repeat (invalid_cycles / 2) tick();
        compare_value(value, '0);          // still locked at zero
        check_valid(valid, 1'b1);
        report_test("invalid length");

        apply_reset();
        repeat (rerun_cycles) tick();
        report_test("reset during run");

        $display("%0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
